// File: verilog/memGeomPkg.sv
// SDRAM address geometry
// Field widths and the raw/field view of one request address

package memGeomPkg;

  localparam int AddrW  = 32;
  localparam int RowW   = 11;
  localparam int BankW  = 2;
  localparam int ColW   = 8;
  localparam int SpareW = 2;
  localparam int GapW   = AddrW - SpareW - RowW - BankW - ColW; // 9 unused bits below the row

  // Bank interleaved map: row 29..19, bank 9..8, column 7..0
  typedef union packed {
    logic [AddrW-1:0] raw;
    struct packed {
      logic [SpareW-1:0] spare;
      logic [RowW-1:0]   row;
      logic [GapW-1:0]   gap;
      logic [BankW-1:0]  bank;
      logic [ColW-1:0]   col;
    } fields;
  } memAddrT;

endpackage

// File: verilog/macReqPkg.sv
// Request queue and arbitration constants
// Entry layout is {address, tag, id}, address on top

package macReqPkg;

  localparam int TagW = 4;
  localparam int IdW  = 3;
  localparam int ReqW = memGeomPkg::AddrW + TagW + IdW; // 39

  localparam int QueueDepthLog = 3; // 8 entries per channel

  // Grants per side before the other side gets a turn
  localparam int BurstW = 3;
  localparam logic [BurstW-1:0] BurstDefault = BurstW'(1);

endpackage

// File: verilog/reqFifo.sv
`timescale 1ns/10ps
// Request queue
// Synchronous circular buffer, head entry visible while not empty

module reqFifo #(
  parameter int DataW    = 8,
  parameter int DepthLog = 3
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             push,
  input  logic [DataW-1:0] pushData,
  input  logic             pop,
  output logic [DataW-1:0] headData,
  output logic             full,
  output logic             empty
);

  logic [DataW-1:0] mem [2**DepthLog];
  logic [DepthLog:0] wrPtr;   // Extra MSB tells full from empty
  logic [DepthLog:0] rdPtr;
  logic doPush;
  logic doPop;

  assign doPush = push & ~full;
  assign doPop  = pop & ~empty;

  assign empty = (wrPtr == rdPtr);
  assign full  = (wrPtr[DepthLog] != rdPtr[DepthLog]) &&
                 (wrPtr[DepthLog-1:0] == rdPtr[DepthLog-1:0]);

  assign headData = mem[rdPtr[DepthLog-1:0]];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1;
      if (doPop)  rdPtr <= rdPtr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr[DepthLog-1:0]] <= pushData;
    end
  end

endmodule

// File: verilog/arbRegs.sv
`timescale 1ns/10ps
// Arbiter configuration register
// Write and read burst limits, loaded on cfgValid

module arbRegs (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic                         cfgValid,
  input  logic [macReqPkg::BurstW-1:0] cfgWrBurst,
  input  logic [macReqPkg::BurstW-1:0] cfgRdBurst,
  output logic [macReqPkg::BurstW-1:0] wrBurst,
  output logic [macReqPkg::BurstW-1:0] rdBurst
);
  import macReqPkg::*;

  // Zero would lock a side out, so it counts as one
  function automatic logic [BurstW-1:0] legalBurst(input logic [BurstW-1:0] val);
    return (val == '0) ? BurstW'(1) : val;
  endfunction

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wrBurst <= BurstDefault;
      rdBurst <= BurstDefault;
    end else if (cfgValid) begin
      wrBurst <= legalBurst(cfgWrBurst);
      rdBurst <= legalBurst(cfgRdBurst);
    end
  end

endmodule

// File: verilog/queueArbiter.sv
`timescale 1ns/10ps
// Write/read queue arbiter
// Round robin between the request queues, each side served up to its burst limit

module queueArbiter (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic                         wrEmpty,
  input  logic                         rdEmpty,
  input  logic [macReqPkg::ReqW-1:0]   wrHead,
  input  logic [macReqPkg::ReqW-1:0]   rdHead,
  input  logic [macReqPkg::BurstW-1:0] wrBurst,
  input  logic [macReqPkg::BurstW-1:0] rdBurst,
  input  logic                         free,
  output logic                         wrPop,
  output logic                         rdPop,
  output logic                         grant,
  output logic                         grantLoad,
  output logic [macReqPkg::ReqW-1:0]   grantEntry
);
  import macReqPkg::*;

  logic              curRd;     // Side in service, 1 = read
  logic [BurstW-1:0] burstCnt;  // Grants given in this burst
  logic [BurstW-1:0] curLimit;
  logic              curReq;
  logic              otherReq;
  logic              stay;
  logic              pickRd;

  assign curLimit = curRd ? rdBurst : wrBurst;
  assign curReq   = curRd ? ~rdEmpty : ~wrEmpty;
  assign otherReq = curRd ? ~wrEmpty : ~rdEmpty;
  assign stay     = curReq & (burstCnt < curLimit);

  // Switch when the burst is spent or the side ran dry,
  // unless the other queue has nothing either
  assign pickRd = (stay | ~otherReq) ? curRd : ~curRd;

  assign grant      = free & (curReq | otherReq);
  assign grantLoad  = pickRd;
  assign grantEntry = pickRd ? rdHead : wrHead;
  assign wrPop      = grant & ~pickRd;
  assign rdPop      = grant & pickRd;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      curRd    <= 1'b0;  // Writes first
      burstCnt <= '0;
    end else if (grant) begin
      curRd <= pickRd;
      if (stay) begin
        burstCnt <= burstCnt + 1'b1;
      end else begin
        burstCnt <= BurstW'(1); // New burst, this grant is its first
      end
    end
  end

endmodule

// File: verilog/bankDecoder.sv
`timescale 1ns/10ps
// Command output stage
// Holds the granted request and splits its address into bank, row and column

module bankDecoder (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          grant,
  input  logic                          grantLoad,
  input  logic [macReqPkg::ReqW-1:0]    grantEntry,
  input  logic                          cmdReady,
  output logic                          free,
  output logic                          cmdValid,
  output logic                          cmdLoad,
  output logic [memGeomPkg::BankW-1:0]  cmdBank,
  output logic [memGeomPkg::RowW-1:0]   cmdRow,
  output logic [memGeomPkg::ColW-1:0]   cmdCol,
  output logic [macReqPkg::TagW-1:0]    cmdTag,
  output logic [macReqPkg::IdW-1:0]     cmdId
);
  import memGeomPkg::*;
  import macReqPkg::*;

  memAddrT addrQ;

  // Empty, or emptied by the consumer this cycle
  assign free = ~cmdValid | cmdReady;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      cmdValid <= 1'b0;
    end else if (grant) begin
      cmdValid <= 1'b1;
    end else if (cmdReady) begin
      cmdValid <= 1'b0;
    end
  end

  // Only loaded when free, so fields hold while stalled
  always_ff @(posedge clk) begin
    if (grant) begin
      addrQ.raw <= grantEntry[ReqW-1 -: AddrW];
      cmdTag    <= grantEntry[TagW+IdW-1 -: TagW];
      cmdId     <= grantEntry[IdW-1:0];
      cmdLoad   <= grantLoad;
    end
  end

  assign cmdBank = addrQ.fields.bank;
  assign cmdRow  = addrQ.fields.row;
  assign cmdCol  = addrQ.fields.col;

endmodule

// File: verilog/macTop.sv
`timescale 1ns/10ps
// Memory access controller front end
// Write and read request queues, burst arbiter and command decode

module macTop (
  input  logic                          clk,
  input  logic                          resetn,
  input  logic                          wrValid,
  input  logic [memGeomPkg::AddrW-1:0]  wrAddr,
  input  logic [macReqPkg::TagW-1:0]    wrTag,
  input  logic [macReqPkg::IdW-1:0]     wrId,
  output logic                          wrReady,
  input  logic                          rdValid,
  input  logic [memGeomPkg::AddrW-1:0]  rdAddr,
  input  logic [macReqPkg::TagW-1:0]    rdTag,
  input  logic [macReqPkg::IdW-1:0]     rdId,
  output logic                          rdReady,
  input  logic                          cfgValid,
  input  logic [macReqPkg::BurstW-1:0]  cfgWrBurst,
  input  logic [macReqPkg::BurstW-1:0]  cfgRdBurst,
  output logic                          cmdValid,
  output logic                          cmdLoad,
  output logic [memGeomPkg::BankW-1:0]  cmdBank,
  output logic [memGeomPkg::RowW-1:0]   cmdRow,
  output logic [memGeomPkg::ColW-1:0]   cmdCol,
  output logic [macReqPkg::TagW-1:0]    cmdTag,
  output logic [macReqPkg::IdW-1:0]     cmdId,
  input  logic                          cmdReady
);
  import macReqPkg::*;

  logic              wrFull, wrEmpty, wrPop;
  logic              rdFull, rdEmpty, rdPop;
  logic [ReqW-1:0]   wrHead;
  logic [ReqW-1:0]   rdHead;
  logic [ReqW-1:0]   grantEntry;
  logic [BurstW-1:0] wrBurst;
  logic [BurstW-1:0] rdBurst;
  logic              grant;
  logic              grantLoad;
  logic              free;

  assign wrReady = ~wrFull;
  assign rdReady = ~rdFull;

  reqFifo #(.DataW(ReqW), .DepthLog(QueueDepthLog)) writeQueue (
    .clk      (clk),
    .resetn   (resetn),
    .push     (wrValid & wrReady),
    .pushData ({wrAddr, wrTag, wrId}),
    .pop      (wrPop),
    .headData (wrHead),
    .full     (wrFull),
    .empty    (wrEmpty)
  );

  reqFifo #(.DataW(ReqW), .DepthLog(QueueDepthLog)) readQueue (
    .clk      (clk),
    .resetn   (resetn),
    .push     (rdValid & rdReady),
    .pushData ({rdAddr, rdTag, rdId}),
    .pop      (rdPop),
    .headData (rdHead),
    .full     (rdFull),
    .empty    (rdEmpty)
  );

  arbRegs burstRegs (
    .clk        (clk),
    .resetn     (resetn),
    .cfgValid   (cfgValid),
    .cfgWrBurst (cfgWrBurst),
    .cfgRdBurst (cfgRdBurst),
    .wrBurst    (wrBurst),
    .rdBurst    (rdBurst)
  );

  queueArbiter arbiter (
    .clk        (clk),
    .resetn     (resetn),
    .wrEmpty    (wrEmpty),
    .rdEmpty    (rdEmpty),
    .wrHead     (wrHead),
    .rdHead     (rdHead),
    .wrBurst    (wrBurst),
    .rdBurst    (rdBurst),
    .free       (free),
    .wrPop      (wrPop),
    .rdPop      (rdPop),
    .grant      (grant),
    .grantLoad  (grantLoad),
    .grantEntry (grantEntry)
  );

  bankDecoder decoder (
    .clk        (clk),
    .resetn     (resetn),
    .grant      (grant),
    .grantLoad  (grantLoad),
    .grantEntry (grantEntry),
    .cmdReady   (cmdReady),
    .free       (free),
    .cmdValid   (cmdValid),
    .cmdLoad    (cmdLoad),
    .cmdBank    (cmdBank),
    .cmdRow     (cmdRow),
    .cmdCol     (cmdCol),
    .cmdTag     (cmdTag),
    .cmdId      (cmdId)
  );

endmodule

// File: verification/macChecker.sv
`timescale 1ns/10ps
// Command checker for the memory access controller front end
// Replays accepted requests through a queue and burst model and compares the command port

module macChecker (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic                         wrValid,
  input  logic [memGeomPkg::AddrW-1:0] wrAddr,
  input  logic [macReqPkg::TagW-1:0]   wrTag,
  input  logic [macReqPkg::IdW-1:0]    wrId,
  input  logic                         wrReady,
  input  logic                         rdValid,
  input  logic [memGeomPkg::AddrW-1:0] rdAddr,
  input  logic [macReqPkg::TagW-1:0]   rdTag,
  input  logic [macReqPkg::IdW-1:0]    rdId,
  input  logic                         rdReady,
  input  logic                         cfgValid,
  input  logic [macReqPkg::BurstW-1:0] cfgWrBurst,
  input  logic [macReqPkg::BurstW-1:0] cfgRdBurst,
  input  logic                         cmdValid,
  input  logic                         cmdLoad,
  input  logic [memGeomPkg::BankW-1:0] cmdBank,
  input  logic [memGeomPkg::RowW-1:0]  cmdRow,
  input  logic [memGeomPkg::ColW-1:0]  cmdCol,
  input  logic [macReqPkg::TagW-1:0]   cmdTag,
  input  logic [macReqPkg::IdW-1:0]    cmdId,
  input  logic                         cmdReady,
  output logic                         idle
);
  import memGeomPkg::*;
  import macReqPkg::*;

  localparam int QueueSlots = 8;

  logic [ReqW-1:0] wrQ [$];
  logic [ReqW-1:0] rdQ [$];
  logic [ReqW-1:0] outEntry;   // Model of the output register
  logic            outValid;
  logic            outRd;
  logic            curRd;
  int              burstCnt;
  int              wrLimit;
  int              rdLimit;
  int              acc [2];    // Index 1 is the read side
  int              taken [2];
  int              accBase [2];
  int              takenBase [2];
  int              cycleErrs;
  int              cycleBase;
  int              endErrs;
  int              endBase;
  int              testsRun;
  int              testsFailed;
  string           testName = "startup";

  function automatic int mismatch(input string what, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
    if (expVal === actVal) return 0;
    $display("mismatch %s %s expected %0h actual %0h", testName, what, expVal, actVal);
    return 1;
  endfunction

  task automatic clearModel();
    wrQ.delete();
    rdQ.delete();
    outValid = 1'b0;
    outRd    = 1'b0;
    curRd    = 1'b0;  // Writes first
    burstCnt = 0;
    wrLimit  = 1;
    rdLimit  = 1;
    idle     = 1'b1;
  endtask

  // Runs just before the rising edge while inputs and outputs are settled
  task automatic modelEdge();
    logic [AddrW-1:0] addr;
    logic [1:0]       avail;
    int               limit;
    addr = outEntry[ReqW-1 -: AddrW];
    cycleErrs += mismatch("cmdValid", 32'(outValid), 32'(cmdValid));
    cycleErrs += mismatch("wrReady", 32'(wrQ.size() < QueueSlots), 32'(wrReady));
    cycleErrs += mismatch("rdReady", 32'(rdQ.size() < QueueSlots), 32'(rdReady));
    if (outValid) begin
      cycleErrs += mismatch("cmdLoad", 32'(outRd), 32'(cmdLoad));
      cycleErrs += mismatch("cmdBank", 32'(addr[9:8]), 32'(cmdBank));
      cycleErrs += mismatch("cmdRow", 32'(addr[29:19]), 32'(cmdRow));
      cycleErrs += mismatch("cmdCol", 32'(addr[7:0]), 32'(cmdCol));
      cycleErrs += mismatch("cmdTag", 32'(outEntry[IdW +: TagW]), 32'(cmdTag));
      cycleErrs += mismatch("cmdId", 32'(outEntry[IdW-1:0]), 32'(cmdId));
    end
    if (cmdValid && cmdReady) taken[cmdLoad]++;  // Commands the DUT hands off
    avail[0] = wrQ.size() != 0;  // Queue heads before this edge's pushes
    avail[1] = rdQ.size() != 0;
    if ((!outValid || cmdReady) && avail != 2'b00) begin
      limit = curRd ? rdLimit : wrLimit;
      if (avail[curRd] && burstCnt < limit) begin
        burstCnt++;
      end else begin
        if (avail[!curRd]) curRd = !curRd;
        burstCnt = 1;
      end
      outRd = curRd;
      if (curRd) outEntry = rdQ.pop_front();
      else outEntry = wrQ.pop_front();
      outValid = 1'b1;
    end else if (cmdReady) begin
      outValid = 1'b0;
    end
    if (wrValid && wrReady) begin
      wrQ.push_back({wrAddr, wrTag, wrId});
      acc[0]++;
    end
    if (rdValid && rdReady) begin
      rdQ.push_back({rdAddr, rdTag, rdId});
      acc[1]++;
    end
    if (cfgValid) begin
      wrLimit = (cfgWrBurst == '0) ? 1 : int'(cfgWrBurst);
      rdLimit = (cfgRdBurst == '0) ? 1 : int'(cfgRdBurst);
    end
    idle = !outValid && wrQ.size() == 0 && rdQ.size() == 0;
  endtask

  always @(negedge clk) begin
    if (!resetn) begin
      clearModel();
    end else begin
      modelEdge();
    end
  end

  task automatic startTest(input string name);
    testName  = name;
    cycleBase = cycleErrs;
    endBase   = endErrs;
    accBase   = acc;
    takenBase = taken;
  endtask

  task automatic checkHeldWrites(input int expHeld);
    endErrs += mismatch("writes held", expHeld, acc[0] - accBase[0]);
  endtask

  task automatic finishTest(input int expWr, input int expRd);
    int errs;
    endErrs += mismatch("writes issued", expWr, taken[0] - takenBase[0]);
    endErrs += mismatch("reads issued", expRd, taken[1] - takenBase[1]);
    errs = cycleErrs - cycleBase + endErrs - endBase;
    testsRun++;
    if (errs != 0) testsFailed++;
    $display("test %s: %0d writes and %0d reads issued, %0d errors", testName,
             taken[0] - takenBase[0], taken[1] - takenBase[1], errs);
  endtask

  function automatic int errorTotal();
    return cycleErrs + endErrs;
  endfunction

  task automatic reportTotals();
    $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorTotal());
  endtask

endmodule

// File: verification/macTb.sv
`timescale 1ns/10ps
// Testbench for the memory access controller front end
// Table of request mixes, each row applied with an optional stall on the command port

module macTb;
  import memGeomPkg::*;
  import macReqPkg::*;

  localparam int NumTests = 7;

  // Expected accept counts are the request counts
  string testName [NumTests] = '{"resetState", "singleWrite", "singleRead", "alternate",
                                 "burst3w2r", "fillQueue", "randomMix"};
  int    cfgWr    [NumTests] = '{1, 1, 1, 1, 3, 1, 2};
  int    cfgRd    [NumTests] = '{1, 1, 1, 1, 2, 1, 0};  // Zero reads as one
  int    numWr    [NumTests] = '{0, 1, 0, 4, 8, 12, 20};
  int    numRd    [NumTests] = '{0, 0, 1, 4, 4, 0, 20};
  int    holdCyc  [NumTests] = '{0, 0, 0, 12, 24, 24, 0};  // cmdReady low this long
  int    heldWr   [NumTests] = '{0, 0, 0, 0, 0, 9, 0};
  bit    useRand  [NumTests] = '{0, 0, 0, 0, 0, 0, 1};

  logic              clk = 1'b0;
  logic              resetn;
  logic              wrValid;
  logic [AddrW-1:0]  wrAddr;
  logic [TagW-1:0]   wrTag;
  logic [IdW-1:0]    wrId;
  logic              wrReady;
  logic              rdValid;
  logic [AddrW-1:0]  rdAddr;
  logic [TagW-1:0]   rdTag;
  logic [IdW-1:0]    rdId;
  logic              rdReady;
  logic              cfgValid;
  logic [BurstW-1:0] cfgWrBurst;
  logic [BurstW-1:0] cfgRdBurst;
  logic              cmdValid;
  logic              cmdLoad;
  logic [BankW-1:0]  cmdBank;
  logic [RowW-1:0]   cmdRow;
  logic [ColW-1:0]   cmdCol;
  logic [TagW-1:0]   cmdTag;
  logic [IdW-1:0]    cmdId;
  logic              cmdReady;
  logic              idle;
  int                seed = 49;
  int                cycles = 0;
  int                cycleLimit;

  always #2 clk = ~clk;

  macTop uut (.*);
  macChecker chk (.*);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // Fixed requests step the address so bank, row and column all move
  task automatic makeRequest(input int t, input bit rd, input int k,
                             output logic [AddrW-1:0] addr, output logic [TagW-1:0] tag,
                             output logic [IdW-1:0] id);
    if (useRand[t]) begin
      addr = $random(seed);
      tag  = TagW'($random(seed));
      id   = IdW'($random(seed));
    end else begin
      addr = (rd ? 32'h4A31_C2E7 : 32'h1F08_5A3C) + 32'(k) * 32'h0409_0D15;
      tag  = TagW'(k + 5);
      id   = IdW'(rd ? k + 2 : k);
    end
  endtask

  task automatic runTest(input int t);
    int wrSent;
    int rdSent;
    int cyc;
    bit wrAcc;
    bit rdAcc;
    wrSent = 0;
    rdSent = 0;
    cyc    = 0;
    chk.startTest(testName[t]);
    cfgValid   = 1'b1;
    cfgWrBurst = BurstW'(cfgWr[t]);
    cfgRdBurst = BurstW'(cfgRd[t]);
    makeRequest(t, 1'b0, 0, wrAddr, wrTag, wrId);
    makeRequest(t, 1'b1, 0, rdAddr, rdTag, rdId);
    while (wrSent < numWr[t] || rdSent < numRd[t] || cyc <= holdCyc[t] || !idle) begin
      if (cyc == holdCyc[t] && heldWr[t] != 0) chk.checkHeldWrites(heldWr[t]);
      wrValid = wrSent < numWr[t];
      rdValid = rdSent < numRd[t];
      if (useRand[t]) cmdReady = 1'($random(seed));
      else cmdReady = cyc >= holdCyc[t];
      @(negedge clk);
      wrAcc = wrValid && wrReady;  // Settled until the next rising edge
      rdAcc = rdValid && rdReady;
      @(posedge clk);
      #1;
      cfgValid = 1'b0;
      cyc++;
      if (wrAcc) begin
        wrSent++;
        makeRequest(t, 1'b0, wrSent, wrAddr, wrTag, wrId);
      end
      if (rdAcc) begin
        rdSent++;
        makeRequest(t, 1'b1, rdSent, rdAddr, rdTag, rdId);
      end
    end
    wrValid  = 1'b0;
    rdValid  = 1'b0;
    cmdReady = 1'b1;
    chk.finishTest(numWr[t], numRd[t]);
  endtask

  initial begin
    resetn     = 1'b0;
    wrValid    = 1'b0;
    wrAddr     = '0;
    wrTag      = '0;
    wrId       = '0;
    rdValid    = 1'b0;
    rdAddr     = '0;
    rdTag      = '0;
    rdId       = '0;
    cfgValid   = 1'b0;
    cfgWrBurst = '0;
    cfgRdBurst = '0;
    cmdReady   = 1'b1;
    cycleLimit = 200;
    for (int t = 0; t < NumTests; t++) begin
      cycleLimit += 40 * (numWr[t] + numRd[t]);
    end
    repeat (2) @(posedge clk);
    #1;
    resetn = 1'b1;
    for (int t = 0; t < NumTests; t++) begin
      runTest(t);
    end
    chk.reportTotals();
    if (chk.errorTotal() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: src.f
verilog/memGeomPkg.sv
verilog/macReqPkg.sv
verilog/reqFifo.sv
verilog/arbRegs.sv
verilog/queueArbiter.sv
verilog/bankDecoder.sv
verilog/macTop.sv
verification/macChecker.sv
verification/macTb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module macTb -f src.f -o macSim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/macSim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
